/* include/axi2apb_consts.svh */
`ifndef AXI2APB_CONSTS_SVH
`define AXI2APB_CONSTS_SVH

// Bus widths, AXI and APB data are the same width
`define AXI2APB_ADDR_W 32
`define AXI2APB_DATA_W 32
`define AXI2APB_ID_W 4

// Outstanding APB beats tracked between execute and result
`define AXI2APB_SIDE_DEPTH 4

// AXI response codes
`define AXI2APB_RESP_OKAY 2'b00
`define AXI2APB_RESP_SLVERR 2'b10

`endif

/* hw/axi2apb_pkg.sv */
`default_nettype none
`include "axi2apb_consts.svh"

package axi2apb_pkg;

    typedef logic [`AXI2APB_ADDR_W-1:0] addr_t;
    typedef logic [`AXI2APB_DATA_W-1:0] data_t;
    typedef logic [`AXI2APB_DATA_W/8-1:0] strb_t;
    typedef logic [`AXI2APB_ID_W-1:0] id_t;
    typedef logic [7:0] len_t;
    typedef logic [1:0] resp_t;
    typedef logic [2:0] prot_t;

    // AW and AR share one layout
    typedef struct packed {
        id_t id;
        addr_t addr;
        len_t len;
        prot_t prot;
    } axi_req_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic last;
    } axi_w_t;

    typedef struct packed {
        id_t id;
        resp_t resp;
    } axi_b_t;

    typedef struct packed {
        id_t id;
        data_t data;
        resp_t resp;
        logic last;
    } axi_r_t;

    // Request as held by decode, addr already aligned
    typedef struct packed {
        logic write;
        id_t id;
        addr_t addr;
        len_t len;
        prot_t prot;
    } burst_t;

    typedef struct packed {
        addr_t paddr;
        data_t pwdata;
        strb_t pstrb;
        prot_t pprot;
        logic pwrite;
        logic first;
        logic last;
    } apb_cmd_t;

    typedef struct packed {
        data_t prdata;
        logic pslverr;
    } apb_rsp_t;

    // One entry per issued APB beat
    typedef struct packed {
        logic write;
        id_t id;
        logic last;
    } side_entry_t;

    typedef enum logic [1:0] {
        EXEC_IDLE,
        EXEC_READ,
        EXEC_WRITE
    } exec_state_t;

    typedef enum logic {
        RSP_IDLE,
        RSP_ACTIVE
    } rsp_state_t;

endpackage

`default_nettype wire

/* hw/axi2apb_req_decode.sv */
`default_nettype none
`include "axi2apb_consts.svh"

module axi2apb_req_decode (
    input  wire logic                  aclk,
    input  wire logic                  aresetn,
    input  wire axi2apb_pkg::axi_req_t i_aw,
    input  wire logic                  i_awvalid,
    input  wire logic                  i_wvalid,
    input  wire axi2apb_pkg::axi_req_t i_ar,
    input  wire logic                  i_arvalid,
    input  wire logic                  i_queue_valid,
    input  wire logic                  i_done,
    output logic                       o_awready,
    output logic                       o_arready,
    output axi2apb_pkg::burst_t        o_burst,
    output logic                       o_busy
);

    localparam int unsigned BEAT_BYTES = `AXI2APB_DATA_W / 8;

    axi2apb_pkg::addr_t align_mask;
    axi2apb_pkg::axi_req_t sel;
    logic can_take;
    logic take_wr;
    logic take_rd;

    assign align_mask = axi2apb_pkg::addr_t'(BEAT_BYTES - 1);

    // Previous burst must fully drain before a new one starts
    assign can_take = !o_busy && !i_queue_valid;

    // Write wins when both are pending
    assign take_wr = can_take && i_awvalid && i_wvalid;
    assign take_rd = can_take && !take_wr && i_arvalid;

    assign o_awready = take_wr;
    assign o_arready = take_rd;
    assign sel = take_wr ? i_aw : i_ar;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_busy <= 1'b0;
        end else if (take_wr || take_rd) begin
            o_busy <= 1'b1;
        end else if (i_done) begin
            o_busy <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (take_wr || take_rd) begin
            o_burst.write <= take_wr;
            o_burst.id <= sel.id;
            o_burst.addr <= sel.addr & ~align_mask;
            o_burst.len <= sel.len;
            o_burst.prot <= sel.prot;
        end
    end

    // Execute may only finish a burst that decode handed out
    a_done_while_busy: assert property (
        @(posedge aclk) disable iff (!aresetn)
        i_done |-> o_busy
    );

endmodule

`default_nettype wire

/* hw/axi2apb_cmd_execute.sv */
`default_nettype none
`include "axi2apb_consts.svh"

module axi2apb_cmd_execute (
    input  wire logic                   aclk,
    input  wire logic                   aresetn,
    input  wire axi2apb_pkg::burst_t    i_burst,
    input  wire logic                   i_busy,
    input  wire axi2apb_pkg::axi_w_t    i_w,
    input  wire logic                   i_wvalid,
    input  wire logic                   i_cmd_ready,
    input  wire logic                   i_side_ready,
    output logic                        o_wready,
    output axi2apb_pkg::apb_cmd_t       o_cmd,
    output logic                        o_cmd_valid,
    output axi2apb_pkg::side_entry_t    o_side,
    output logic                        o_side_valid,
    output logic                        o_done
);

    localparam int unsigned BEAT_BYTES = `AXI2APB_DATA_W / 8;

    axi2apb_pkg::exec_state_t state;
    axi2apb_pkg::len_t beat_cnt;
    axi2apb_pkg::addr_t cur_addr;
    logic is_write;
    logic last_beat;
    logic issue;

    assign is_write = (state == axi2apb_pkg::EXEC_WRITE);
    assign last_beat = (beat_cnt == i_burst.len);

    // A beat goes out only when the APB side and the side queue can both take it
    assign issue = (state != axi2apb_pkg::EXEC_IDLE) && i_cmd_ready && i_side_ready &&
                   (!is_write || i_wvalid);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= axi2apb_pkg::EXEC_IDLE;
            beat_cnt <= '0;
            cur_addr <= '0;
        end else begin
            case (state)
                axi2apb_pkg::EXEC_IDLE: begin
                    if (i_busy) begin
                        state <= i_burst.write ? axi2apb_pkg::EXEC_WRITE
                                               : axi2apb_pkg::EXEC_READ;
                        beat_cnt <= '0;
                        cur_addr <= i_burst.addr;
                    end
                end
                axi2apb_pkg::EXEC_READ,
                axi2apb_pkg::EXEC_WRITE: begin
                    if (issue) begin
                        if (last_beat) begin
                            state <= axi2apb_pkg::EXEC_IDLE;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                            cur_addr <= cur_addr + axi2apb_pkg::addr_t'(BEAT_BYTES);
                        end
                    end
                end
                default: state <= axi2apb_pkg::EXEC_IDLE;
            endcase
        end
    end

    always_comb begin
        o_cmd.paddr = cur_addr;
        o_cmd.pwdata = is_write ? i_w.data : '0;
        o_cmd.pstrb = is_write ? i_w.strb : '0;
        o_cmd.pprot = i_burst.prot;
        o_cmd.pwrite = is_write;
        o_cmd.first = (beat_cnt == '0);
        o_cmd.last = last_beat;
    end

    assign o_side.write = is_write;
    assign o_side.id = i_burst.id;
    assign o_side.last = last_beat;

    assign o_cmd_valid = issue;
    assign o_side_valid = issue;
    assign o_wready = issue && is_write;
    assign o_done = issue && last_beat;

    // Commands only go out while decode holds a burst
    a_cmd_in_burst: assert property (
        @(posedge aclk) disable iff (!aresetn)
        o_cmd_valid |-> i_busy
    );

    // Master's wlast must agree with the AWLEN count
    a_wlast_matches: assert property (
        @(posedge aclk) disable iff (!aresetn)
        o_wready |-> (i_w.last == o_cmd.last)
    );

endmodule

`default_nettype wire

/* hw/axi2apb_side_queue.sv */
`default_nettype none
`include "axi2apb_consts.svh"

module axi2apb_side_queue (
    input  wire logic                     aclk,
    input  wire logic                     aresetn,
    input  wire axi2apb_pkg::side_entry_t i_wr,
    input  wire logic                     i_wr_valid,
    output logic                          o_wr_ready,
    output axi2apb_pkg::side_entry_t      o_rd,
    output logic                          o_rd_valid,
    input  wire logic                     i_rd_ready
);

    localparam int unsigned DEPTH = `AXI2APB_SIDE_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    axi2apb_pkg::side_entry_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_wr;
    logic do_rd;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign o_wr_ready = (count != CNT_W'(DEPTH));
    assign o_rd_valid = (count != '0);
    assign do_wr = i_wr_valid && o_wr_ready;
    assign do_rd = i_rd_ready && o_rd_valid;
    assign o_rd = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // Execute is expected to hold off on a full queue
    a_no_write_when_full: assert property (
        @(posedge aclk) disable iff (!aresetn)
        i_wr_valid |-> o_wr_ready
    );

endmodule

`default_nettype wire

/* hw/axi2apb_rsp_result.sv */
`default_nettype none
`include "axi2apb_consts.svh"

module axi2apb_rsp_result (
    input  wire logic                     aclk,
    input  wire logic                     aresetn,
    input  wire axi2apb_pkg::apb_rsp_t    i_rsp,
    input  wire logic                     i_rsp_valid,
    output logic                          o_rsp_ready,
    input  wire axi2apb_pkg::side_entry_t i_side,
    input  wire logic                     i_side_valid,
    output logic                          o_side_ready,
    output axi2apb_pkg::axi_r_t           o_r,
    output logic                          o_rvalid,
    input  wire logic                     i_rready,
    output axi2apb_pkg::axi_b_t           o_b,
    output logic                          o_bvalid,
    input  wire logic                     i_bready
);

    axi2apb_pkg::rsp_state_t state;
    logic err_q;
    logic pair_valid;
    logic take;
    logic burst_err;

    assign pair_valid = i_rsp_valid && i_side_valid;

    // Hold the response and its entry until the AXI side can take them
    assign take = pair_valid && (i_side.write ? i_bready : i_rready);

    assign o_rsp_ready = take;
    assign o_side_ready = take;

    // Error seen on any earlier beat of this write burst
    assign burst_err = i_rsp.pslverr || ((state == axi2apb_pkg::RSP_ACTIVE) && err_q);

    assign o_rvalid = take && !i_side.write;
    assign o_r.id = i_side.id;
    assign o_r.data = i_rsp.prdata;
    assign o_r.resp = i_rsp.pslverr ? `AXI2APB_RESP_SLVERR : `AXI2APB_RESP_OKAY;
    assign o_r.last = i_side.last;

    // Only the final write beat surfaces on B
    assign o_bvalid = take && i_side.write && i_side.last;
    assign o_b.id = i_side.id;
    assign o_b.resp = burst_err ? `AXI2APB_RESP_SLVERR : `AXI2APB_RESP_OKAY;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= axi2apb_pkg::RSP_IDLE;
            err_q <= 1'b0;
        end else if (take && i_side.write) begin
            if (i_side.last) begin
                state <= axi2apb_pkg::RSP_IDLE;
                err_q <= 1'b0;
            end else begin
                state <= axi2apb_pkg::RSP_ACTIVE;
                err_q <= burst_err;
            end
        end
        // Read beats pass straight through
    end

    // The APB target only answers beats that were issued
    a_rsp_has_side: assert property (
        @(posedge aclk) disable iff (!aresetn)
        i_rsp_valid |-> i_side_valid
    );

endmodule

`default_nettype wire

/* hw/axi2apb_bridge.sv */
`default_nettype none

module axi2apb_bridge (
    input  wire logic                  aclk,
    input  wire logic                  aresetn,
    // Write address
    input  wire axi2apb_pkg::axi_req_t i_aw,
    input  wire logic                  i_awvalid,
    output logic                       o_awready,
    // Write data
    input  wire axi2apb_pkg::axi_w_t   i_w,
    input  wire logic                  i_wvalid,
    output logic                       o_wready,
    // Write response
    output axi2apb_pkg::axi_b_t        o_b,
    output logic                       o_bvalid,
    input  wire logic                  i_bready,
    // Read address
    input  wire axi2apb_pkg::axi_req_t i_ar,
    input  wire logic                  i_arvalid,
    output logic                       o_arready,
    // Read data
    output axi2apb_pkg::axi_r_t        o_r,
    output logic                       o_rvalid,
    input  wire logic                  i_rready,
    // APB command and response packets
    output axi2apb_pkg::apb_cmd_t      o_cmd,
    output logic                       o_cmd_valid,
    input  wire logic                  i_cmd_ready,
    input  wire axi2apb_pkg::apb_rsp_t i_rsp,
    input  wire logic                  i_rsp_valid,
    output logic                       o_rsp_ready
);

    axi2apb_pkg::burst_t burst;
    logic busy;
    logic done;
    axi2apb_pkg::side_entry_t side_wr;
    logic side_wr_valid;
    logic side_wr_ready;
    axi2apb_pkg::side_entry_t side_rd;
    logic side_rd_valid;
    logic side_rd_ready;

    axi2apb_req_decode decode_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_aw          (i_aw),
        .i_awvalid     (i_awvalid),
        .i_wvalid      (i_wvalid),
        .i_ar          (i_ar),
        .i_arvalid     (i_arvalid),
        .i_queue_valid (side_rd_valid),
        .i_done        (done),
        .o_awready     (o_awready),
        .o_arready     (o_arready),
        .o_burst       (burst),
        .o_busy        (busy)
    );

    axi2apb_cmd_execute execute_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_burst      (burst),
        .i_busy       (busy),
        .i_w          (i_w),
        .i_wvalid     (i_wvalid),
        .i_cmd_ready  (i_cmd_ready),
        .i_side_ready (side_wr_ready),
        .o_wready     (o_wready),
        .o_cmd        (o_cmd),
        .o_cmd_valid  (o_cmd_valid),
        .o_side       (side_wr),
        .o_side_valid (side_wr_valid),
        .o_done       (done)
    );

    axi2apb_side_queue side_queue_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_wr       (side_wr),
        .i_wr_valid (side_wr_valid),
        .o_wr_ready (side_wr_ready),
        .o_rd       (side_rd),
        .o_rd_valid (side_rd_valid),
        .i_rd_ready (side_rd_ready)
    );

    axi2apb_rsp_result result_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_rsp        (i_rsp),
        .i_rsp_valid  (i_rsp_valid),
        .o_rsp_ready  (o_rsp_ready),
        .i_side       (side_rd),
        .i_side_valid (side_rd_valid),
        .o_side_ready (side_rd_ready),
        .o_r          (o_r),
        .o_rvalid     (o_rvalid),
        .i_rready     (i_rready),
        .o_b          (o_b),
        .o_bvalid     (o_bvalid),
        .i_bready     (i_bready)
    );

endmodule

`default_nettype wire

/* bench/apb_target_model.sv */
`default_nettype none

module apb_target_model (
    input  wire logic                  aclk,
    input  wire logic                  aresetn,
    input  wire axi2apb_pkg::apb_cmd_t i_cmd,
    input  wire logic                  i_cmd_valid,
    output logic                       o_cmd_ready,
    output axi2apb_pkg::apb_rsp_t      o_rsp,
    output logic                       o_rsp_valid,
    input  wire logic                  i_rsp_ready
);

    axi2apb_pkg::data_t mem [256];
    axi2apb_pkg::apb_rsp_t pending [$];
    axi2apb_pkg::apb_rsp_t rsp;
    logic [31:0] rng;
    logic [1:0] delay;
    logic [7:0] idx;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hA500_0000 ^ (32'(i) * 32'h0001_0203);
        end
        rng = 32'd38;
        delay = '0;
        o_cmd_ready = 1'b0;
        o_rsp = '0;
        o_rsp_valid = 1'b0;
    end

    always @(posedge aclk) begin
        if (o_rsp_valid && i_rsp_ready) begin
            void'(pending.pop_front());
            delay = rng[9:8];
        end
        if (i_cmd_valid) begin
            idx = i_cmd.paddr[9:2];
            // Region 0xE000..0xEFFF answers with an error, reads there return zero
            rsp.pslverr = (i_cmd.paddr[15:12] == 4'hE);
            rsp.prdata = (i_cmd.pwrite || rsp.pslverr) ? '0 : mem[idx];
            if (i_cmd.pwrite && !rsp.pslverr) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_cmd.pstrb[b]) begin
                        mem[idx][8*b +: 8] = i_cmd.pwdata[8*b +: 8];
                    end
                end
            end
            pending.push_back(rsp);
        end
        #1;
        rng = lcg_next(rng);
        if (delay != 0 && pending.size() != 0) begin
            delay = delay - 1'b1;
        end
        o_cmd_ready = aresetn && (rng[21:20] != 2'b00);
        o_rsp_valid = aresetn && (pending.size() != 0) && (delay == 0);
        o_rsp = (pending.size() != 0) ? pending[0] : '0;
    end

endmodule

`default_nettype wire

/* bench/axi2apb_tb.sv */
`default_nettype none
`include "axi2apb_consts.svh"

module axi2apb_tb;

    localparam int SEL_AW = 0;
    localparam int SEL_AR = 1;
    localparam int SEL_W = 2;
    localparam int SEL_IDLE = 3;
    localparam int WAIT_LIMIT = 200;

    logic aclk;
    logic aresetn;
    axi2apb_pkg::axi_req_t i_aw;
    logic i_awvalid;
    logic o_awready;
    axi2apb_pkg::axi_w_t i_w;
    logic i_wvalid;
    logic o_wready;
    axi2apb_pkg::axi_b_t o_b;
    logic o_bvalid;
    logic i_bready;
    axi2apb_pkg::axi_req_t i_ar;
    logic i_arvalid;
    logic o_arready;
    axi2apb_pkg::axi_r_t o_r;
    logic o_rvalid;
    logic i_rready;
    axi2apb_pkg::apb_cmd_t o_cmd;
    logic o_cmd_valid;
    logic i_cmd_ready;
    axi2apb_pkg::apb_rsp_t i_rsp;
    logic i_rsp_valid;
    logic o_rsp_ready;

    // Expected commands and responses in issue order and a mirror of the target memory
    axi2apb_pkg::data_t shadow [256];
    axi2apb_pkg::apb_cmd_t exp_c [256];
    axi2apb_pkg::axi_r_t exp_r [256];
    axi2apb_pkg::axi_b_t exp_b [256];
    axi2apb_pkg::apb_cmd_t exp_c_head;
    axi2apb_pkg::axi_r_t exp_r_head;
    axi2apb_pkg::axi_b_t exp_b_head;
    int exp_c_wr = 0;
    int exp_c_rd = 0;
    int exp_r_wr = 0;
    int exp_r_rd = 0;
    int exp_b_wr = 0;
    int exp_b_rd = 0;
    logic req_seen;
    logic toggle_ready;
    logic [31:0] rng;
    int err_count;
    int errs_before;
    int tests_ok;
    int tests_bad;

    axi2apb_bridge dut_i (.*);

    apb_target_model apb_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_cmd       (o_cmd),
        .i_cmd_valid (o_cmd_valid),
        .o_cmd_ready (i_cmd_ready),
        .o_rsp       (i_rsp),
        .o_rsp_valid (i_rsp_valid),
        .i_rsp_ready (o_rsp_ready)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    assign exp_c_head = exp_c[exp_c_rd[7:0]];
    assign exp_r_head = exp_r[exp_r_rd[7:0]];
    assign exp_b_head = exp_b[exp_b_rd[7:0]];

    always @(posedge aclk) begin
        if (o_cmd_valid && i_cmd_ready) begin
            exp_c_rd <= exp_c_rd + 1;
        end
        if (o_rvalid && i_rready) begin
            exp_r_rd <= exp_r_rd + 1;
        end
        if (o_bvalid && i_bready) begin
            exp_b_rd <= exp_b_rd + 1;
        end
    end

    // Back-pressure on R and B
    always @(posedge aclk) begin
        #1;
        rng = lcg_next(rng);
        i_rready = !toggle_ready || rng[16];
        i_bready = !toggle_ready || rng[17];
    end

    a_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
        !req_seen |-> !(o_awready || o_arready || o_wready || o_cmd_valid ||
                        o_rsp_ready || o_rvalid || o_bvalid))
        else begin
            $display("Bridge output went active before any request at time %0t", $time);
            err_count++;
        end

    a_write_first: assert property (@(posedge aclk) disable iff (!aresetn)
        (i_awvalid && i_wvalid) |-> !o_arready)
        else begin
            $display("Read accepted while a write was pending at time %0t", $time);
            err_count++;
        end

    a_cmd_match: assert property (@(posedge aclk) disable iff (!aresetn)
        (o_cmd_valid && i_cmd_ready) |->
            (exp_c_rd != exp_c_wr && o_cmd.paddr == exp_c_head.paddr &&
             o_cmd.pwrite == exp_c_head.pwrite && o_cmd.pprot == exp_c_head.pprot &&
             o_cmd.first == exp_c_head.first && o_cmd.last == exp_c_head.last &&
             (!o_cmd.pwrite || (o_cmd.pwdata == exp_c_head.pwdata &&
                                o_cmd.pstrb == exp_c_head.pstrb))))
        else begin
            $display("ERR %0t: APB command %h, expected %h", $time, o_cmd, exp_c_head);
            err_count++;
        end

    a_r_match: assert property (@(posedge aclk) disable iff (!aresetn)
        o_rvalid |-> (exp_r_rd != exp_r_wr && o_r == exp_r_head))
        else begin
            $display("ERR %0t: R beat id %0h data %h resp %0d last %0b, expected %h",
                     $time, o_r.id, o_r.data, o_r.resp, o_r.last, exp_r_head);
            err_count++;
        end

    a_b_match: assert property (@(posedge aclk) disable iff (!aresetn)
        o_bvalid |-> (exp_b_rd != exp_b_wr && o_b == exp_b_head))
        else begin
            $display("ERR %0t: B id %0h resp %0d, expected %h",
                     $time, o_b.id, o_b.resp, exp_b_head);
            err_count++;
        end

    function automatic logic probe(input int sel);
        case (sel)
            SEL_AW: return o_awready;
            SEL_AR: return o_arready;
            SEL_W: return o_wready;
            default: return (exp_r_rd == exp_r_wr) && (exp_b_rd == exp_b_wr);
        endcase
    endfunction

    // Returns just after the edge on which the condition was seen
    task automatic wait_for(input int sel, input string what);
        int cycles;
        cycles = 0;
        @(negedge aclk);
        while (!probe(sel) && cycles < WAIT_LIMIT) begin
            @(negedge aclk);
            cycles++;
        end
        if (!probe(sel)) begin
            $display("Timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
            err_count++;
        end
        @(posedge aclk);
        #1;
    endtask

    task automatic raise_ar(input axi2apb_pkg::id_t id, input axi2apb_pkg::addr_t addr,
                            input int len);
        i_ar.id = id;
        i_ar.addr = addr;
        i_ar.len = axi2apb_pkg::len_t'(len);
        i_ar.prot = 3'b000;
        i_arvalid = 1'b1;
        req_seen = 1'b1;
    endtask

    task automatic write_burst(input axi2apb_pkg::id_t id, input axi2apb_pkg::addr_t addr,
                               input int len, input axi2apb_pkg::data_t salt);
        axi2apb_pkg::addr_t a;
        axi2apb_pkg::axi_b_t exp_resp;
        axi2apb_pkg::apb_cmd_t cmd;
        exp_resp.id = id;
        exp_resp.resp = `AXI2APB_RESP_OKAY;
        i_aw.id = id;
        i_aw.addr = addr;
        i_aw.len = axi2apb_pkg::len_t'(len);
        i_aw.prot = 3'b010;
        i_awvalid = 1'b1;
        req_seen = 1'b1;
        for (int k = 0; k <= len; k++) begin
            a = (addr & ~32'h3) + 32'(4 * k);
            i_w.data = (a * 32'h9E37_79B9) ^ salt;
            i_w.strb = 4'hF;
            i_w.last = (k == len);
            i_wvalid = 1'b1;
            cmd.paddr = a;
            cmd.pwdata = i_w.data;
            cmd.pstrb = i_w.strb;
            cmd.pprot = 3'b010;
            cmd.pwrite = 1'b1;
            cmd.first = (k == 0);
            cmd.last = (k == len);
            exp_c[exp_c_wr[7:0]] = cmd;
            exp_c_wr++;
            if (a[15:12] == 4'hE) begin
                exp_resp.resp = `AXI2APB_RESP_SLVERR;
            end else begin
                shadow[a[9:2]] = i_w.data;
            end
            if (k == len) begin
                exp_b[exp_b_wr[7:0]] = exp_resp;
                exp_b_wr++;
            end
            if (k == 0) begin
                wait_for(SEL_AW, "awready");
                i_awvalid = 1'b0;
            end
            wait_for(SEL_W, "wready");
        end
        i_wvalid = 1'b0;
    endtask

    task automatic read_burst(input axi2apb_pkg::id_t id, input axi2apb_pkg::addr_t addr,
                              input int len);
        axi2apb_pkg::addr_t a;
        axi2apb_pkg::axi_r_t beat;
        axi2apb_pkg::apb_cmd_t cmd;
        for (int k = 0; k <= len; k++) begin
            a = (addr & ~32'h3) + 32'(4 * k);
            cmd.paddr = a;
            cmd.pwdata = '0;
            cmd.pstrb = '0;
            cmd.pprot = 3'b000;
            cmd.pwrite = 1'b0;
            cmd.first = (k == 0);
            cmd.last = (k == len);
            exp_c[exp_c_wr[7:0]] = cmd;
            exp_c_wr++;
            beat.id = id;
            beat.last = (k == len);
            if (a[15:12] == 4'hE) begin
                beat.data = '0;
                beat.resp = `AXI2APB_RESP_SLVERR;
            end else begin
                beat.data = shadow[a[9:2]];
                beat.resp = `AXI2APB_RESP_OKAY;
            end
            exp_r[exp_r_wr[7:0]] = beat;
            exp_r_wr++;
        end
        raise_ar(id, addr, len);
        wait_for(SEL_AR, "arready");
        i_arvalid = 1'b0;
    endtask

    task automatic finish_test(input string name);
        wait_for(SEL_IDLE, "the outstanding responses");
        if (err_count == errs_before) begin
            tests_ok++;
            $display("PASS %s", name);
        end else begin
            tests_bad++;
            $display("FAIL %s", name);
        end
        errs_before = err_count;
    endtask

    initial begin
        i_aw = '0;
        i_awvalid = 1'b0;
        i_w = '0;
        i_wvalid = 1'b0;
        i_bready = 1'b1;
        i_ar = '0;
        i_arvalid = 1'b0;
        i_rready = 1'b1;
        aresetn = 1'b0;
        req_seen = 1'b0;
        toggle_ready = 1'b0;
        rng = 32'd38;
        err_count = 0;
        errs_before = 0;
        tests_ok = 0;
        tests_bad = 0;
        repeat (10) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        repeat (20) @(posedge aclk);
        #1;
        finish_test("idle after reset");

        write_burst(4'h1, 32'h0000_0040, 0, 32'h1111_0000);
        read_burst(4'h2, 32'h0000_0040, 0);
        finish_test("single write then read");

        write_burst(4'h3, 32'h0000_0106, 3, 32'h2222_0000);
        read_burst(4'h5, 32'h0000_0104, 3);
        finish_test("unaligned burst of four");

        // Only the fourth beat lands at 0xE000
        write_burst(4'h6, 32'h0000_DFF4, 3, 32'h3333_0000);
        read_burst(4'h7, 32'h0000_DFF4, 3);
        finish_test("error region");

        raise_ar(4'h9, 32'h0000_0200, 1);
        write_burst(4'h8, 32'h0000_0200, 1, 32'h4444_0000);
        read_burst(4'h9, 32'h0000_0200, 1);
        finish_test("write wins over read");

        toggle_ready = 1'b1;
        for (int i = 0; i < 4; i++) begin
            write_burst(4'(i), 32'h0000_0300 + 32'(i * 16), 2, 32'h5555_0000);
            read_burst(4'(i + 8), 32'h0000_0300 + 32'(i * 16), 2);
        end
        finish_test("random R and B back-pressure");
        toggle_ready = 1'b0;

        $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_ok, tests_bad, err_count);
        if (tests_bad == 0 && err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* axi2apb.f */
+incdir+include
hw/axi2apb_pkg.sv
hw/axi2apb_req_decode.sv
hw/axi2apb_cmd_execute.sv
hw/axi2apb_side_queue.sv
hw/axi2apb_rsp_result.sv
hw/axi2apb_bridge.sv
bench/apb_target_model.sv
bench/axi2apb_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f axi2apb.f \
    --top-module axi2apb_tb -o axi2apb_sim || exit 1
./obj_dir/axi2apb_sim > sim.log 2>&1 || echo "Testbench failed" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
